//--- filelist.f
rtl/fpu_pkg.sv
rtl/fpu_add_sub.sv
rtl/fpu_mul.sv
rtl/fpu_regs.sv
rtl/fpu_ctrl.sv
rtl/fpu_top.sv
testbench/tb_clock.sv
testbench/tb_fpu.sv

//--- rtl/fpu_add_sub.sv
// combinational single precision adder and subtractor with truncating normalization
module fpu_add_sub
  import fpu_pkg::*;
(
  input  logic [float_width-1:0] operand_a,
  input  logic [float_width-1:0] operand_b,
  input  logic                   subtract,
  output logic [float_width-1:0] result
);

  logic [exp_width-1:0]   exp_a;
  logic [exp_width-1:0]   exp_b;
  logic                   a_zero;
  logic                   b_zero;
  logic [mant_width-1:0]  mant_a;
  logic [mant_width-1:0]  mant_b;
  logic [mant_width-1:0]  aligned_a;
  logic [mant_width-1:0]  aligned_b;
  logic [exp_width-1:0]   exp_base;
  logic [mant_width+1:0]  signed_a;
  logic [mant_width+1:0]  signed_b;
  logic [mant_width+1:0]  sum;
  logic [mant_width+1:0]  magnitude;
  logic [mant_width+1:0]  norm_mant;
  logic [exp_width+1:0]   norm_exp;
  logic [4:0]             lead_pos;
  logic [4:0]             left_shift;

  assign exp_a  = operand_a[float_width-2 -: exp_width];
  assign exp_b  = operand_b[float_width-2 -: exp_width];
  assign a_zero = (exp_a == '0);
  assign b_zero = (exp_b == '0);

  // hidden bit, a zero exponent means the value is zero
  assign mant_a = a_zero ? '0 : {1'b1, operand_a[frac_width-1:0]};
  assign mant_b = b_zero ? '0 : {1'b1, operand_b[frac_width-1:0]};

  // align to the larger exponent
  always_comb begin
    aligned_a = mant_a;
    aligned_b = mant_b;
    if (a_zero) begin
      exp_base = exp_b;
    end else if (b_zero) begin
      exp_base = exp_a;
    end else if (exp_a < exp_b) begin
      aligned_a = mant_a >> (exp_b - exp_a);
      exp_base  = exp_b;
    end else begin
      aligned_b = mant_b >> (exp_a - exp_b);
      exp_base  = exp_a;
    end
  end

  // two's complement add with two spare bits for carry and sign
  assign signed_a  = operand_a[float_width-1] ? -{2'b00, aligned_a} : {2'b00, aligned_a};
  assign signed_b  = operand_b[float_width-1] ? -{2'b00, aligned_b} : {2'b00, aligned_b};
  assign sum       = subtract ? (signed_a - signed_b) : (signed_a + signed_b);
  assign magnitude = sum[mant_width+1] ? -sum : sum;

  // highest set bit below the carry positions
  always_comb begin
    lead_pos = '0;
    for (int i = 0; i < mant_width; i++) begin
      if (magnitude[i]) lead_pos = 5'(i);
    end
  end

  assign left_shift = 5'(mant_width - 1) - lead_pos;

  always_comb begin
    norm_exp  = {2'b00, exp_base};
    norm_mant = magnitude;
    if (magnitude[mant_width+1]) begin
      norm_mant = magnitude >> 2;
      norm_exp  = norm_exp + 10'd2;
    end else if (magnitude[mant_width]) begin
      norm_mant = magnitude >> 1;
      norm_exp  = norm_exp + 10'd1;
    end else begin
      norm_mant = magnitude << left_shift;
      norm_exp  = norm_exp - {5'b00000, left_shift};
    end
  end

  // exact cancellation gives +0
  assign result = (sum == '0) ? '0 :
                  {sum[mant_width+1], norm_exp[exp_width-1:0], norm_mant[frac_width-1:0]};

endmodule

//--- rtl/fpu_ctrl.sv
// command state machine and arithmetic sequencer of the FPU, linked by a go/done handshake
module fpu_ctrl
  import fpu_pkg::*;
(
  input  logic           clk,
  input  logic           arst,
  input  logic           op_start,
  input  e_fpu_operation operation,
  input  logic           end_ack,
  input  logic           mul_last,
  output logic           busy,
  output logic           cmd_end,
  output logic           copy_a_to_b,
  output logic           mul_load,
  output logic           mul_step,
  output logic           capture
);

  e_main_state  main_state;
  e_main_state  main_next;
  e_arith_state arith_state;
  e_arith_state arith_next;
  logic         go;
  logic         done;

  // command machine
  always_comb begin
    main_next = main_state;
    case (main_state)
      main_idle_st:     if (op_start) main_next = main_wait_st;
      main_wait_st:     if (done) main_next = main_finish_st;
      main_finish_st:   if (!done) main_next = main_wait_ack_st;
      main_wait_ack_st: if (end_ack) main_next = main_idle_st;
      default:          main_next = main_idle_st;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      main_state <= main_idle_st;
      busy       <= 1'b0;
      cmd_end    <= 1'b0;
      go         <= 1'b0;
    end else begin
      main_state <= main_next;
      busy       <= (main_next != main_idle_st);
      cmd_end    <= (main_next == main_wait_ack_st);
      go         <= (main_next == main_wait_st);
    end
  end

  // sequencer, one path per operation
  always_comb begin
    arith_next = arith_state;
    case (arith_state)
      idle_st: begin
        if (go) begin
          case (operation)
            op_add, op_sub: arith_next = add_sub_st;
            op_mul:         arith_next = mul_start_st;
            op_square:      arith_next = square_copy_st;
            // constants and unknown codes need no datapath
            default:        arith_next = const_st;
          endcase
        end
      end
      add_sub_st:      arith_next = result_valid_st;
      square_copy_st:  arith_next = mul_start_st;
      mul_start_st:    arith_next = mul_run_st;
      mul_run_st:      if (mul_last) arith_next = mul_result_st;
      mul_result_st:   arith_next = result_valid_st;
      const_st:        arith_next = result_valid_st;
      // hold done until the command machine drops go
      result_valid_st: if (!go) arith_next = idle_st;
      default:         arith_next = idle_st;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      arith_state <= idle_st;
      done        <= 1'b0;
      capture     <= 1'b0;
      copy_a_to_b <= 1'b0;
      mul_load    <= 1'b0;
      mul_step    <= 1'b0;
    end else begin
      arith_state <= arith_next;
      done        <= (arith_next == result_valid_st);
      // first cycle of result_valid_st only
      capture     <= (arith_next == result_valid_st) && (arith_state != result_valid_st);
      copy_a_to_b <= (arith_next == square_copy_st);
      mul_load    <= (arith_next == mul_start_st);
      mul_step    <= (arith_next == mul_run_st);
    end
  end

  a_end_while_busy: assert property (
    @(posedge clk) disable iff (arst) cmd_end |-> busy
  );

  a_no_step_in_idle: assert property (
    @(posedge clk) disable iff (arst) mul_step |-> (arith_state != idle_st)
  );

endmodule

//--- rtl/fpu_mul.sv
// sequential shift-and-add single precision multiplier, one add and one shift per step
module fpu_mul
  import fpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst,
  input  logic [float_width-1:0] operand_a,
  input  logic [float_width-1:0] operand_b,
  input  logic                   mul_load,
  input  logic                   mul_step,
  output logic                   mul_last,
  output logic [float_width-1:0] result
);

  logic [exp_width-1:0]    exp_a;
  logic [exp_width-1:0]    exp_b;
  logic                    any_zero;
  logic [mant_width-1:0]   multiplicand;
  // upper half collects the product, lower half shifts the multiplier out
  logic [2*mant_width:0]   prod_mult;
  logic [mant_width:0]     partial_sum;
  logic [4:0]              step_count;
  logic                    shift_phase;
  logic                    top_set;
  logic [exp_width+1:0]    exp_sum;
  logic [frac_width-1:0]   frac;

  assign exp_a    = operand_a[float_width-2 -: exp_width];
  assign exp_b    = operand_b[float_width-2 -: exp_width];
  assign any_zero = (exp_a == '0) || (exp_b == '0);

  assign partial_sum = prod_mult[2*mant_width:mant_width] + {1'b0, multiplicand};
  assign mul_last    = (step_count == 5'(mul_steps)) && !shift_phase;

  // step control
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      step_count  <= '0;
      shift_phase <= 1'b0;
    end else if (mul_load) begin
      step_count  <= '0;
      shift_phase <= 1'b0;
    end else if (mul_step && !mul_last) begin
      if (!shift_phase) step_count <= step_count + 5'd1;
      shift_phase <= !shift_phase;
    end
  end

  // product datapath
  always_ff @(posedge clk) begin
    if (mul_load) begin
      multiplicand <= {1'b1, operand_a[frac_width-1:0]};
      prod_mult    <= {{(mant_width+1){1'b0}}, 1'b1, operand_b[frac_width-1:0]};
    end else if (mul_step && !mul_last) begin
      if (shift_phase) begin
        prod_mult <= prod_mult >> 1;
      end else if (prod_mult[0]) begin
        prod_mult[2*mant_width:mant_width] <= partial_sum;
      end
    end
  end

  // product of two 1.x mantissas is 1.x or 1x.x
  assign top_set = prod_mult[2*mant_width-1];
  assign frac    = top_set ? prod_mult[2*mant_width-2 -: frac_width]
                           : prod_mult[2*mant_width-3 -: frac_width];
  assign exp_sum = {2'b00, exp_a} + {2'b00, exp_b} - 10'(exp_bias) + {9'd0, top_set};

  // packed once, on the last step
  always_ff @(posedge clk) begin
    if (mul_step && mul_last) begin
      if (any_zero) begin
        result <= '0;
      end else begin
        result <= {operand_a[float_width-1] ^ operand_b[float_width-1],
                   exp_sum[exp_width-1:0], frac};
      end
    end
  end

  a_step_bound: assert property (
    @(posedge clk) disable iff (arst) step_count <= 5'(mul_steps)
  );

endmodule

//--- rtl/fpu_pkg.sv
// shared codes, state types, register map and IEEE-754 constants for the byte-bus FPU
package fpu_pkg;

  // operation codes written to the operation register, code 4 is reserved
  typedef enum logic [3:0] {
    op_add     = 4'd0,
    op_sub     = 4'd1,
    op_mul     = 4'd2,
    op_square  = 4'd3,
    op_k_pi    = 4'd5,
    op_k_piby2 = 4'd6
  } e_fpu_operation;

  // host command machine
  typedef enum logic [1:0] {
    main_idle_st,
    main_wait_st,
    main_finish_st,
    main_wait_ack_st
  } e_main_state;

  // arithmetic sequencer
  typedef enum logic [2:0] {
    idle_st,
    add_sub_st,
    square_copy_st,
    mul_start_st,
    mul_run_st,
    mul_result_st,
    const_st,
    result_valid_st
  } e_arith_state;

  // single precision field layout
  localparam int float_width = 32;
  localparam int exp_width   = 8;
  localparam int frac_width  = 23;
  localparam int mant_width  = 24;
  localparam int exp_bias    = 127;

  // add/shift pairs per multiplication
  localparam int mul_steps = 24;

  // host bus
  localparam int addr_width = 4;
  localparam int data_width = 8;

  // register map, multi-byte registers are little endian
  localparam logic [addr_width-1:0] addr_a0 = 4'd0;
  localparam logic [addr_width-1:0] addr_a1 = 4'd1;
  localparam logic [addr_width-1:0] addr_a2 = 4'd2;
  localparam logic [addr_width-1:0] addr_a3 = 4'd3;
  localparam logic [addr_width-1:0] addr_b0 = 4'd4;
  localparam logic [addr_width-1:0] addr_b1 = 4'd5;
  localparam logic [addr_width-1:0] addr_b2 = 4'd6;
  localparam logic [addr_width-1:0] addr_b3 = 4'd7;
  localparam logic [addr_width-1:0] addr_op = 4'd8;
  localparam logic [addr_width-1:0] addr_r0 = 4'd9;
  localparam logic [addr_width-1:0] addr_r1 = 4'd10;
  localparam logic [addr_width-1:0] addr_r2 = 4'd11;
  localparam logic [addr_width-1:0] addr_r3 = 4'd12;

  // constant results and the operand reset value
  localparam logic [float_width-1:0] k_pi          = 32'h40490fda;
  localparam logic [float_width-1:0] k_piby2       = 32'h3fc90fda;
  localparam logic [float_width-1:0] reset_operand = 32'h3f800000;

endpackage

//--- rtl/fpu_regs.sv
// host register file of the FPU with byte access, result capture and operand copy
module fpu_regs
  import fpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   cs,
  input  logic                   rd,
  input  logic                   wr,
  input  logic [addr_width-1:0]  addr,
  input  logic [data_width-1:0]  databus_in,
  output logic [data_width-1:0]  databus_out,
  input  logic                   busy,
  output logic                   op_start,
  output e_fpu_operation         operation,
  output logic [float_width-1:0] operand_a,
  output logic [float_width-1:0] operand_b,
  input  logic                   copy_a_to_b,
  input  logic                   capture,
  input  logic [float_width-1:0] add_sub_result,
  input  logic [float_width-1:0] mul_result
);

  logic                   wr_en;
  logic [float_width-1:0] result_reg;
  logic [float_width-1:0] selected_result;

  // host writes are dropped while an operation runs
  assign wr_en = !cs && !wr && !busy;

  // result source for the current operation
  always_comb begin
    case (operation)
      op_add, op_sub:    selected_result = add_sub_result;
      op_mul, op_square: selected_result = mul_result;
      op_k_pi:           selected_result = k_pi;
      op_k_piby2:        selected_result = k_piby2;
      default:           selected_result = '0;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      operand_a  <= reset_operand;
      operand_b  <= reset_operand;
      operation  <= op_add;
      result_reg <= '0;
      op_start   <= 1'b0;
    end else begin
      op_start <= wr_en && (addr == addr_op);
      if (wr_en) begin
        case (addr)
          addr_a0: operand_a[7:0]   <= databus_in;
          addr_a1: operand_a[15:8]  <= databus_in;
          addr_a2: operand_a[23:16] <= databus_in;
          addr_a3: operand_a[31:24] <= databus_in;
          addr_b0: operand_b[7:0]   <= databus_in;
          addr_b1: operand_b[15:8]  <= databus_in;
          addr_b2: operand_b[23:16] <= databus_in;
          addr_b3: operand_b[31:24] <= databus_in;
          addr_op: operation <= e_fpu_operation'(databus_in[3:0]);
          default: ;
        endcase
      end
      // square multiplies A by itself
      if (copy_a_to_b) begin
        operand_b <= operand_a;
      end
      // result also lands in A so that operations chain
      if (capture) begin
        result_reg <= selected_result;
        operand_a  <= selected_result;
      end
    end
  end

  // read mux, zero when not selected or unmapped
  always_comb begin
    databus_out = '0;
    if (!cs && !rd) begin
      case (addr)
        addr_a0: databus_out = operand_a[7:0];
        addr_a1: databus_out = operand_a[15:8];
        addr_a2: databus_out = operand_a[23:16];
        addr_a3: databus_out = operand_a[31:24];
        addr_b0: databus_out = operand_b[7:0];
        addr_b1: databus_out = operand_b[15:8];
        addr_b2: databus_out = operand_b[23:16];
        addr_b3: databus_out = operand_b[31:24];
        addr_op: databus_out = {4'b0000, operation};
        addr_r0: databus_out = result_reg[7:0];
        addr_r1: databus_out = result_reg[15:8];
        addr_r2: databus_out = result_reg[23:16];
        addr_r3: databus_out = result_reg[31:24];
        default: databus_out = '0;
      endcase
    end
  end

  // sequencer strobes only come while the command machine reports busy
  a_strobe_in_busy: assert property (
    @(posedge clk) disable iff (arst) (capture || copy_a_to_b) |-> busy
  );

endmodule

//--- rtl/fpu_top.sv
// top level of the byte-bus FPU coprocessor, joins registers, control and datapaths
module fpu_top
  import fpu_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst,
  input  logic                  cs,
  input  logic                  rd,
  input  logic                  wr,
  input  logic [addr_width-1:0] addr,
  input  logic [data_width-1:0] databus_in,
  output logic [data_width-1:0] databus_out,
  input  logic                  end_ack,
  output logic                  cmd_end,
  output logic                  busy
);

  e_fpu_operation         operation;
  logic                   op_start;
  logic [float_width-1:0] operand_a;
  logic [float_width-1:0] operand_b;
  logic [float_width-1:0] add_sub_result;
  logic [float_width-1:0] mul_result;
  logic                   copy_a_to_b;
  logic                   capture;
  logic                   mul_load;
  logic                   mul_step;
  logic                   mul_last;

  fpu_regs i_fpu_regs (
    .clk            (clk),
    .arst           (arst),
    .cs             (cs),
    .rd             (rd),
    .wr             (wr),
    .addr           (addr),
    .databus_in     (databus_in),
    .databus_out    (databus_out),
    .busy           (busy),
    .op_start       (op_start),
    .operation      (operation),
    .operand_a      (operand_a),
    .operand_b      (operand_b),
    .copy_a_to_b    (copy_a_to_b),
    .capture        (capture),
    .add_sub_result (add_sub_result),
    .mul_result     (mul_result)
  );

  fpu_ctrl i_fpu_ctrl (
    .clk         (clk),
    .arst        (arst),
    .op_start    (op_start),
    .operation   (operation),
    .end_ack     (end_ack),
    .mul_last    (mul_last),
    .busy        (busy),
    .cmd_end     (cmd_end),
    .copy_a_to_b (copy_a_to_b),
    .mul_load    (mul_load),
    .mul_step    (mul_step),
    .capture     (capture)
  );

  // subtract select follows the operation register
  fpu_add_sub i_fpu_add_sub (
    .operand_a (operand_a),
    .operand_b (operand_b),
    .subtract  (operation == op_sub),
    .result    (add_sub_result)
  );

  fpu_mul i_fpu_mul (
    .clk       (clk),
    .arst      (arst),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .mul_load  (mul_load),
    .mul_step  (mul_step),
    .mul_last  (mul_last),
    .result    (mul_result)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the FPU testbench with Verilator, runs it and checks the log for failures

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_fpu -Mdir obj_dir -o tb_fpu > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_fpu > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0

//--- testbench/tb_clock.sv
// clock and reset source for the FPU testbench, instantiated by the testbench top
module tb_clock (
  output logic clk,
  output logic arst
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles = 3;

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release on a falling edge, away from the flops
  initial begin
    arst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst = 1'b0;
  end

endmodule

//--- testbench/tb_fpu.sv
// directed testbench for the byte-bus FPU, used as the simulation top together with tb_clock
module tb_fpu
  import fpu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_ops       = 20;
  localparam int cycles_per_op = 200;

  logic                  clk;
  logic                  arst;
  logic                  cs;
  logic                  rd;
  logic                  wr;
  logic [addr_width-1:0] addr;
  logic [data_width-1:0] databus_in;
  logic [data_width-1:0] databus_out;
  logic                  end_ack;
  logic                  cmd_end;
  logic                  busy;
  integer                seed;

  tb_clock i_tb_clock (
    .clk  (clk),
    .arst (arst)
  );

  fpu_top i_fpu_top (
    .clk         (clk),
    .arst        (arst),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .addr        (addr),
    .databus_in  (databus_in),
    .databus_out (databus_out),
    .end_ack     (end_ack),
    .cmd_end     (cmd_end),
    .busy        (busy)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      fail_run($sformatf("error: %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      fail_run($sformatf("error: %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // one byte per access, inputs change on the falling edge
  task automatic bus_write(input logic [3:0] a, input logic [7:0] d);
    @(negedge clk);
    cs         = 1'b0;
    wr         = 1'b0;
    addr       = a;
    databus_in = d;
    @(negedge clk);
    cs = 1'b1;
    wr = 1'b1;
  endtask

  task automatic bus_read(input logic [3:0] a, output logic [7:0] d);
    @(negedge clk);
    cs   = 1'b0;
    rd   = 1'b0;
    addr = a;
    @(negedge clk);
    d  = databus_out;
    cs = 1'b1;
    rd = 1'b1;
  endtask

  task automatic write_word(input logic [3:0] base, input logic [31:0] value);
    for (int i = 0; i < 4; i++) begin
      bus_write(base + 4'(i), value[8*i +: 8]);
    end
  endtask

  task automatic read_word(input logic [3:0] base, output logic [31:0] value);
    logic [7:0] byte_val;
    for (int i = 0; i < 4; i++) begin
      bus_read(base + 4'(i), byte_val);
      value[8*i +: 8] = byte_val;
    end
  endtask

  task automatic wait_cmd_end();
    int cycles;
    cycles = 0;
    while (cmd_end !== 1'b1) begin
      if (cycles == cycles_per_op) begin
        fail_run("cmd_end never rose after the operation was started");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // busy and cmd_end must drop at the edge that sees end_ack
  task automatic acknowledge_end();
    @(negedge clk);
    end_ack = 1'b1;
    @(negedge clk);
    end_ack = 1'b0;
    check_bit("busy", 1'b0, busy);
    check_bit("cmd_end", 1'b0, cmd_end);
  endtask

  task automatic run_op(input e_fpu_operation op, output logic [31:0] result);
    bus_write(addr_op, {4'b0000, op});
    wait_cmd_end();
    check_bit("busy", 1'b1, busy);
    read_word(addr_r0, result);
    acknowledge_end();
  endtask

  task automatic run_and_check(input logic [31:0] a, input logic [31:0] b,
                               input e_fpu_operation op, input logic [31:0] expected);
    logic [31:0] result;
    write_word(addr_a0, a);
    write_word(addr_b0, b);
    run_op(op, result);
    check_word("result", expected, result);
  endtask

  // small integers convert exactly, msb sets the exponent
  function automatic logic [31:0] int_to_float(input int unsigned value);
    int          msb;
    logic [7:0]  exp_field;
    logic [31:0] frac_bits;
    msb = 0;
    for (int i = 0; i < 32; i++) begin
      if (value[i]) msb = i;
    end
    exp_field = 8'(127 + msb);
    frac_bits = value << (23 - msb);
    return (value == 0) ? 32'h0 : {1'b0, exp_field, frac_bits[22:0]};
  endfunction

  task automatic test_reset_map();
    logic [31:0] word;
    logic [7:0]  byte_val;
    check_bit("busy", 1'b0, busy);
    check_bit("cmd_end", 1'b0, cmd_end);
    read_word(addr_a0, word);
    check_word("operand_a", 32'h3f800000, word);
    read_word(addr_b0, word);
    check_word("operand_b", 32'h3f800000, word);
    read_word(addr_r0, word);
    check_word("result", 32'h00000000, word);
    write_word(addr_a0, 32'h12345678);
    write_word(addr_b0, 32'h9abcdef0);
    read_word(addr_a0, word);
    check_word("operand_a", 32'h12345678, word);
    read_word(addr_b0, word);
    check_word("operand_b", 32'h9abcdef0, word);
    bus_read(4'd13, byte_val);
    check_word("databus_out", 32'h0, {24'h0, byte_val});
  endtask

  task automatic test_add_sub();
    run_and_check(32'h3fc00000, 32'h40100000, op_add, 32'h40700000);
    run_and_check(32'h40000000, 32'h40400000, op_sub, 32'hbf800000);
    run_and_check(32'h40a00000, 32'h40a00000, op_sub, 32'h00000000);
    // zero operand passes the other through
    run_and_check(32'h00000000, 32'h40e00000, op_add, 32'h40e00000);
  endtask

  task automatic test_mul_square();
    logic [31:0] result;
    logic [31:0] word;
    int unsigned x;
    int unsigned y;
    run_and_check(32'h40400000, 32'hc0200000, op_mul, 32'hc0f00000);
    write_word(addr_a0, 32'h40400000);
    write_word(addr_b0, 32'h00000000);
    run_op(op_square, result);
    check_word("result", 32'h41100000, result);
    read_word(addr_b0, word);
    check_word("operand_b", 32'h40400000, word);
    for (int i = 0; i < 10; i++) begin
      x = $unsigned($random(seed)) % 15 + 1;
      y = $unsigned($random(seed)) % 15 + 1;
      run_and_check(int_to_float(x), int_to_float(y), op_mul, int_to_float(x * y));
    end
  endtask

  task automatic test_const_chain();
    logic [31:0] result;
    logic [31:0] word;
    run_op(op_k_pi, result);
    check_word("result", 32'h40490fda, result);
    read_word(addr_a0, word);
    check_word("operand_a", 32'h40490fda, word);
    // result sits in A, so adding zero returns pi
    write_word(addr_b0, 32'h00000000);
    run_op(op_add, result);
    check_word("result", 32'h40490fda, result);
    run_op(op_k_piby2, result);
    check_word("result", 32'h3fc90fda, result);
  endtask

  task automatic test_handshake();
    logic [31:0] word;
    int          cycles;
    write_word(addr_a0, 32'h40000000);
    write_word(addr_b0, 32'h40400000);
    bus_write(addr_op, {4'b0000, op_mul});
    cycles = 0;
    while (busy !== 1'b1) begin
      if (cycles == cycles_per_op) begin
        fail_run("busy never rose after the operation was started");
      end
      @(negedge clk);
      cycles++;
    end
    // dropped while busy
    write_word(addr_b0, 32'h00000000);
    wait_cmd_end();
    repeat (20) begin
      @(negedge clk);
      check_bit("busy", 1'b1, busy);
      check_bit("cmd_end", 1'b1, cmd_end);
    end
    read_word(addr_b0, word);
    check_word("operand_b", 32'h40400000, word);
    read_word(addr_r0, word);
    check_word("result", 32'h40c00000, word);
    acknowledge_end();
  endtask

  initial begin
    cs         = 1'b1;
    rd         = 1'b1;
    wr         = 1'b1;
    addr       = '0;
    databus_in = '0;
    end_ack    = 1'b0;
    seed       = 96;
    wait (arst === 1'b0);
    test_reset_map();
    test_add_sub();
    test_mul_square();
    test_const_chain();
    test_handshake();
    $display("NO ERRORS");
    $finish;
  end

  // budget scales with the number of operations
  initial begin
    repeat (num_ops * cycles_per_op) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", num_ops * cycles_per_op);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule
